// ==== design/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit (
    input  cpuPkg::aluOp_e          aluOp,
    input  logic [2:0]              funct3,
    input  logic                    funct7b5,
    input  logic                    isRegOp,
    input  logic [cpuPkg::XLEN-1:0] opA,
    input  logic [cpuPkg::XLEN-1:0] opB,
    output logic [cpuPkg::XLEN-1:0] result,
    output logic                    branchTaken
);
    import cpuPkg::*;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT
    } aluFunc_e;

    aluFunc_e func;

    // funct7 bit 5 only means sub on register ops, addi reuses it as imm
    always_comb begin
        func = OP_ADD;
        if (aluOp == ALU_FUNCT) begin
            case (funct3)
                3'b000:  func = (isRegOp && funct7b5) ? OP_SUB : OP_ADD;
                3'b010:  func = OP_SLT;
                3'b100:  func = OP_XOR;
                3'b110:  func = OP_OR;
                3'b111:  func = OP_AND;
                default: func = OP_ADD;
            endcase
        end
    end

    always_comb begin
        case (func)
            OP_SUB:  result = opA - opB;
            OP_AND:  result = opA & opB;
            OP_OR:   result = opA | opB;
            OP_XOR:  result = opA ^ opB;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            default: result = opA + opB;
        endcase
    end

    // beq on funct3 000, bne on 001
    assign branchTaken = funct3[0] ? (opA != opB) : (opA == opB);

endmodule

// ==== design/cpuPkg.sv ====
package cpuPkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    // unified word memory depth
    localparam int MEM_WORDS = 1024;

    // one fetch or data access holds the bus for four states
    typedef enum logic [3:0] {
        IF_1  = 4'd0,
        IF_2  = 4'd1,
        IF_3  = 4'd2,
        IF_4  = 4'd3,
        ID    = 4'd4,
        EX_1  = 4'd5,
        EX_2  = 4'd6,
        MEM_1 = 4'd7,
        MEM_2 = 4'd8,
        MEM_3 = 4'd9,
        MEM_4 = 4'd10,
        WB    = 4'd11,
        HALT  = 4'd12
    } cpuState_e;

    // RV32I major opcodes kept in this core
    typedef enum logic [6:0] {
        ARITHMETIC     = 7'b0110011,
        ARITHMETIC_IMM = 7'b0010011,
        LOAD           = 7'b0000011,
        STORE          = 7'b0100011,
        BRANCH         = 7'b1100011,
        JAL            = 7'b1101111,
        JALR           = 7'b1100111,
        ECALL          = 7'b1110011
    } opcode_e;

    typedef enum logic {
        SRC_PC = 1'b0,
        SRC_A  = 1'b1
    } aluSrcA_e;

    typedef enum logic [1:0] {
        SRC_B    = 2'b00,
        SRC_FOUR = 2'b01,
        SRC_IMM  = 2'b10
    } aluSrcB_e;

    // ALU_FUNCT means the ALU looks at funct3/funct7
    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,
        ALU_FUNCT = 2'b10
    } aluOp_e;

    typedef struct packed {
        logic     pcWriteNotCond;
        logic     pcWrite;
        logic     iOrD;
        logic     memRead;
        logic     memWrite;
        logic     memToReg;
        logic     irWrite;
        logic     pcSource;
        aluOp_e   aluOp;
        aluSrcB_e aluSrcB;
        aluSrcA_e aluSrcA;
        logic     regWrite;
    } ctrlWord_t;

    // every strobe low, ALU idling on PC + B
    localparam ctrlWord_t CTRL_IDLE = '{
        pcWriteNotCond: 1'b0,
        pcWrite:        1'b0,
        iOrD:           1'b0,
        memRead:        1'b0,
        memWrite:       1'b0,
        memToReg:       1'b0,
        irWrite:        1'b0,
        pcSource:       1'b0,
        aluOp:          ALU_ADD,
        aluSrcB:        SRC_B,
        aluSrcA:        SRC_PC,
        regWrite:       1'b0
    };

endpackage

// ==== design/immGen.sv ====
`timescale 1ns/1ps

module immGen (
    input  logic [cpuPkg::XLEN-1:0] instr,
    output logic [cpuPkg::XLEN-1:0] imm
);
    import cpuPkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(instr[6:0]);

    always_comb begin
        case (opcode)
            ARITHMETIC_IMM, LOAD, JALR: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            // B and J offsets are in halfwords, bit 0 is implied zero
            BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            JAL: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== design/microController.sv ====
`timescale 1ns/1ps

module microController (
    input  cpuPkg::cpuState_e currentState,
    input  cpuPkg::opcode_e   opcode,
    input  logic              branchTaken,
    output cpuPkg::ctrlWord_t ctrl,
    output logic              isEcall
);
    import cpuPkg::*;

    always_comb begin
        ctrl = CTRL_IDLE;
        isEcall = 1'b0;

        case (currentState)
            // fetch holds the read for four cycles, IR latches on the last
            IF_1, IF_2, IF_3: begin
                ctrl.memRead = 1'b1;
                ctrl.iOrD = 1'b0;
            end
            IF_4: begin
                ctrl.memRead = 1'b1;
                ctrl.iOrD = 1'b0;
                ctrl.irWrite = 1'b1;
            end
            // PC + 4 goes to ALUOut here
            ID: begin
                isEcall = (opcode == ECALL);
                ctrl.aluSrcA = SRC_PC;
                ctrl.aluSrcB = SRC_FOUR;
                ctrl.aluOp = ALU_ADD;
            end
            EX_1, EX_2: begin
                case (opcode)
                    ARITHMETIC: begin
                        ctrl.aluSrcA = SRC_A;
                        ctrl.aluSrcB = SRC_B;
                        ctrl.aluOp = ALU_FUNCT;
                    end
                    ARITHMETIC_IMM: begin
                        ctrl.aluSrcA = SRC_A;
                        ctrl.aluSrcB = SRC_IMM;
                        ctrl.aluOp = ALU_FUNCT;
                    end
                    LOAD, STORE: begin
                        // effective address A + imm
                        ctrl.aluSrcA = SRC_A;
                        ctrl.aluSrcB = SRC_IMM;
                        ctrl.aluOp = ALU_ADD;
                    end
                    BRANCH: begin
                        if (currentState == EX_1) begin
                            // compare rs1 against rs2
                            ctrl.aluSrcA = SRC_A;
                            ctrl.aluSrcB = SRC_B;
                            ctrl.aluOp = ALU_FUNCT;
                            // fall through to ALUOut (PC + 4) on a failed compare
                            ctrl.pcWriteNotCond = ~branchTaken;
                            ctrl.pcSource = 1'b1;
                        end else begin
                            // only reached when taken, so PC + imm goes straight in
                            ctrl.aluSrcA = SRC_PC;
                            ctrl.aluSrcB = SRC_IMM;
                            ctrl.aluOp = ALU_ADD;
                            ctrl.pcSource = 1'b0;
                            ctrl.pcWrite = 1'b1;
                        end
                    end
                    default: begin
                        // jal / jalr keep the link value PC + 4 in ALUOut
                        ctrl.aluSrcA = SRC_PC;
                        ctrl.aluSrcB = SRC_FOUR;
                        ctrl.aluOp = ALU_ADD;
                    end
                endcase
            end
            MEM_1, MEM_2, MEM_3: begin
                ctrl.iOrD = 1'b1;
                if (opcode == LOAD) begin
                    ctrl.memRead = 1'b1;
                end else begin
                    ctrl.memWrite = 1'b1;
                end
            end
            MEM_4: begin
                ctrl.iOrD = 1'b1;
                if (opcode == LOAD) begin
                    ctrl.memRead = 1'b1;
                end else begin
                    // store ends here, so advance the PC
                    ctrl.memWrite = 1'b1;
                    ctrl.aluSrcA = SRC_PC;
                    ctrl.aluSrcB = SRC_FOUR;
                    ctrl.aluOp = ALU_ADD;
                    ctrl.pcSource = 1'b0;
                    ctrl.pcWrite = 1'b1;
                end
            end
            WB: begin
                ctrl.regWrite = 1'b1;
                ctrl.pcWrite = 1'b1;
                ctrl.pcSource = 1'b0;
                ctrl.aluOp = ALU_ADD;
                case (opcode)
                    LOAD: begin
                        ctrl.memToReg = 1'b1;
                        ctrl.aluSrcA = SRC_PC;
                        ctrl.aluSrcB = SRC_FOUR;
                    end
                    JAL: begin
                        ctrl.aluSrcA = SRC_PC;
                        ctrl.aluSrcB = SRC_IMM;
                    end
                    JALR: begin
                        ctrl.aluSrcA = SRC_A;
                        ctrl.aluSrcB = SRC_IMM;
                    end
                    default: begin
                        // arithmetic, rd from ALUOut
                        ctrl.aluSrcA = SRC_PC;
                        ctrl.aluSrcB = SRC_FOUR;
                    end
                endcase
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== design/multiCycleCpu.sv ====
`timescale 1ns/1ps

module multiCycleCpu (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [cpuPkg::XLEN-1:0] memRdata,
    output logic [cpuPkg::XLEN-1:0] memAddr,
    output logic                    memRead,
    output logic                    memWrite,
    output logic [cpuPkg::XLEN-1:0] memWdata,
    output logic                    halted
);
    import cpuPkg::*;

    cpuState_e currentState;
    ctrlWord_t ctrl;
    opcode_e   opcode;
    logic      isEcall;
    logic      branchTaken;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] ir;
    logic [XLEN-1:0] mdr;
    logic [XLEN-1:0] aReg;
    logic [XLEN-1:0] bReg;
    logic [XLEN-1:0] aluOut;

    logic [XLEN-1:0] rdata1;
    logic [XLEN-1:0] rdata2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] aluOpA;
    logic [XLEN-1:0] aluOpB;
    logic [XLEN-1:0] aluResult;
    logic [XLEN-1:0] pcNext;
    logic [XLEN-1:0] regWdata;
    logic            pcEn;

    assign opcode = opcode_e'(ir[6:0]);

    stateSequencer uSeq (
        .clk          (clk),
        .rst          (rst),
        .opcode       (opcode),
        .branchTaken  (branchTaken),
        .isEcall      (isEcall),
        .currentState (currentState),
        .halted       (halted)
    );

    microController uCtrl (
        .currentState (currentState),
        .opcode       (opcode),
        .branchTaken  (branchTaken),
        .ctrl         (ctrl),
        .isEcall      (isEcall)
    );

    regFile uRegs (
        .clk    (clk),
        .rs1    (ir[19:15]),
        .rs2    (ir[24:20]),
        .rd     (ir[11:7]),
        .we     (ctrl.regWrite),
        .wdata  (regWdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    immGen uImm (
        .instr (ir),
        .imm   (imm)
    );

    assign aluOpA = (ctrl.aluSrcA == SRC_A) ? aReg : pc;

    always_comb begin
        case (ctrl.aluSrcB)
            SRC_FOUR: aluOpB = 32'd4;
            SRC_IMM:  aluOpB = imm;
            default:  aluOpB = bReg;
        endcase
    end

    aluUnit uAlu (
        .aluOp       (ctrl.aluOp),
        .funct3      (ir[14:12]),
        .funct7b5    (ir[30]),
        .isRegOp     (opcode == ARITHMETIC),
        .opA         (aluOpA),
        .opB         (aluOpB),
        .result      (aluResult),
        .branchTaken (branchTaken)
    );

    // bit 0 clear is the jalr rule; every other target is already aligned
    assign pcNext = ctrl.pcSource ? aluOut : {aluResult[XLEN-1:1], 1'b0};
    assign pcEn = ctrl.pcWrite | (ctrl.pcWriteNotCond & ~branchTaken);
    assign regWdata = ctrl.memToReg ? mdr : aluOut;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (pcEn) begin
            pc <= pcNext;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) begin
            ir <= memRdata;
        end
        // operands read once IR is settled
        if (currentState == ID) begin
            aReg <= rdata1;
            bReg <= rdata2;
        end
        // ALUOut holds still through MEM and WB
        if (currentState == ID || currentState == EX_1 || currentState == EX_2) begin
            aluOut <= aluResult;
        end
        if (currentState == MEM_4 && ctrl.memRead) begin
            mdr <= memRdata;
        end
    end

    assign memAddr = ctrl.iOrD ? aluOut : pc;
    assign memRead = ctrl.memRead;
    assign memWrite = ctrl.memWrite;
    assign memWdata = bReg;

endmodule

// ==== design/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic                          clk,
    input  logic [cpuPkg::REG_ADDR_W-1:0] rs1,
    input  logic [cpuPkg::REG_ADDR_W-1:0] rs2,
    input  logic [cpuPkg::REG_ADDR_W-1:0] rd,
    input  logic                          we,
    input  logic [cpuPkg::XLEN-1:0]       wdata,
    output logic [cpuPkg::XLEN-1:0]       rdata1,
    output logic [cpuPkg::XLEN-1:0]       rdata2
);
    import cpuPkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // x0 never stored, so force the zero on read
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== design/stateSequencer.sv ====
`timescale 1ns/1ps

module stateSequencer (
    input  logic              clk,
    input  logic              rst,
    input  cpuPkg::opcode_e   opcode,
    input  logic              branchTaken,
    input  logic              isEcall,
    output cpuPkg::cpuState_e currentState,
    output logic              halted
);
    import cpuPkg::*;

    cpuState_e nextState;

    always_comb begin
        nextState = IF_1;
        case (currentState)
            IF_1: nextState = IF_2;
            IF_2: nextState = IF_3;
            IF_3: nextState = IF_4;
            IF_4: nextState = ID;
            ID:   nextState = isEcall ? HALT : EX_1;
            EX_1: begin
                if (opcode == BRANCH && !branchTaken) begin
                    nextState = IF_1;
                end else begin
                    nextState = EX_2;
                end
            end
            EX_2: begin
                case (opcode)
                    LOAD, STORE: nextState = MEM_1;
                    ARITHMETIC, ARITHMETIC_IMM, JAL, JALR: nextState = WB;
                    default: nextState = IF_1;
                endcase
            end
            MEM_1: nextState = MEM_2;
            MEM_2: nextState = MEM_3;
            MEM_3: nextState = MEM_4;
            MEM_4: nextState = (opcode == LOAD) ? WB : IF_1;
            WB:   nextState = IF_1;
            // stays here until reset
            HALT: nextState = HALT;
            default: nextState = IF_1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            currentState <= IF_1;
        end else begin
            currentState <= nextState;
        end
    end

    assign halted = (currentState == HALT);

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module cpuTb \
    --Mdir obj_dir -o cpuSim
./obj_dir/cpuSim 2>&1 | tee sim.log
if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
else
    exit 1
fi

// ==== sim/cpuBus_chk.sv ====
`timescale 1ns/1ps

module cpuBusChk (
    input logic                    clk,
    input logic                    rst,
    input logic [cpuPkg::XLEN-1:0] memAddr,
    input logic                    memRead,
    input logic                    memWrite,
    input logic [cpuPkg::XLEN-1:0] memWdata,
    input logic                    halted
);
    import cpuPkg::*;

    noReadWrite: assert property (@(posedge clk) disable iff (rst)
        !(memRead && memWrite))
        else $error("memRead and memWrite high together");

    wordAligned: assert property (@(posedge clk) disable iff (rst)
        (memRead || memWrite) |-> (memAddr[1:0] == 2'b00))
        else $error("unaligned memory address");

    // four cycle store burst with address and data held
    writeBurst: assert property (@(posedge clk) disable iff (rst)
        $rose(memWrite) |-> ##1 (memWrite && $stable(memAddr) && $stable(memWdata))
            ##1 (memWrite && $stable(memAddr) && $stable(memWdata))
            ##1 (memWrite && $stable(memAddr) && $stable(memWdata))
            ##1 !memWrite)
        else $error("store burst not four stable cycles");

    quietHalt: assert property (@(posedge clk) disable iff (rst)
        halted |-> (!memRead && !memWrite))
        else $error("memory activity after halt");

endmodule

bind multiCycleCpu cpuBusChk busChk (
    .clk      (clk),
    .rst      (rst),
    .memAddr  (memAddr),
    .memRead  (memRead),
    .memWrite (memWrite),
    .memWdata (memWdata),
    .halted   (halted)
);

// ==== sim/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;
    import cpuPkg::*;

    localparam int CLK_PERIOD = 20;
    localparam string DATA_FILE = "sim/cpu_testdata.txt";

    logic            clk;
    logic            rst;
    logic [XLEN-1:0] memRdata;
    logic [XLEN-1:0] memAddr;
    logic            memRead;
    logic            memWrite;
    logic [XLEN-1:0] memWdata;
    logic            halted;

    // unified word memory
    logic [XLEN-1:0] mem [MEM_WORDS];

    logic [XLEN-1:0] expAddr [$];
    logic [XLEN-1:0] expData [$];
    int              expCycles;
    int              storeIdx;
    int              cycleCount;
    int              readRun;
    logic            dataLoaded;
    logic            prevWrite;

    multiCycleCpu UUT (
        .clk      (clk),
        .rst      (rst),
        .memRdata (memRdata),
        .memAddr  (memAddr),
        .memRead  (memRead),
        .memWrite (memWrite),
        .memWdata (memWdata),
        .halted   (halted)
    );

    // data only while the read strobe is up
    assign memRdata = memRead ? mem[memAddr[11:2]] : '0;

    always @(posedge clk) begin
        if (memWrite) begin
            mem[memAddr[11:2]] <= memWdata;
        end
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic checkEqual(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic failRun(input string reason);
        $display("error at %0t ns: %s", $time, reason);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    // P addr word, S addr data, C cycles; '#' starts a comment line
    task automatic loadTestData();
        int          fd;
        int          n;
        string       line;
        byte         tag;
        logic [31:0] a;
        logic [31:0] d;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            failRun("cannot open the test data file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 3 || line[0] == "#") begin
                continue;
            end
            tag = line[0];
            if (tag == "C") begin
                n = $sscanf(line, "%c %d", tag, expCycles);
                if (n != 2) begin
                    failRun("bad cycle count line in the test data file");
                end
            end else begin
                n = $sscanf(line, "%c %h %h", tag, a, d);
                if (n != 3) begin
                    failRun("bad program or store line in the test data file");
                end
                if (tag == "P") begin
                    mem[a[11:2]] = d;
                end else if (tag == "S") begin
                    expAddr.push_back(a);
                    expData.push_back(d);
                end
            end
        end
        $fclose(fd);
    endtask

    // one log entry per write burst
    always @(negedge clk) begin
        if (rst) begin
            prevWrite = 1'b0;
            readRun = 0;
        end else begin
            if (memWrite && !prevWrite) begin
                if (storeIdx >= expAddr.size()) begin
                    failRun("store seen after the expected list was used up");
                end
                checkEqual("store address", memAddr, expAddr[storeIdx]);
                checkEqual("store data", memWdata, expData[storeIdx]);
                storeIdx++;
            end
            // fetch and load reads each hold the strobe four cycles
            if (memRead) begin
                readRun++;
            end else if (readRun != 0) begin
                checkEqual("read burst length", readRun, 32'd4);
                readRun = 0;
            end
            prevWrite = memWrite;
        end
    end

    // watchdog
    initial begin
        wait (dataLoaded);
        #((expCycles + 50) * CLK_PERIOD);
        $display("error at %0t ns: the processor never halted", $time);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst = 1'b1;
        storeIdx = 0;
        cycleCount = 0;
        readRun = 0;
        expCycles = 0;
        dataLoaded = 1'b0;
        prevWrite = 1'b0;
        void'($urandom(32'hbab9));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = $urandom();
        end
        loadTestData();
        dataLoaded = 1'b1;

        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        // edges from reset release until HALT is reached
        do begin
            @(posedge clk);
            cycleCount++;
            @(negedge clk);
        end while (!halted);
        checkEqual("cycles to halt", cycleCount, expCycles);

        // core must stay quiet once halted
        repeat (10) @(negedge clk);
        checkEqual("halted level", {31'd0, halted}, 32'd1);

        if (storeIdx != expAddr.size()) begin
            $display("error: only %0d of %0d expected stores were seen",
                     storeIdx, expAddr.size());
            $display("STATUS: FAIL");
            $fatal(1, "missing stores");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

// ==== sim/cpu_testdata.txt ====
# P byte_addr word : program or data word, S byte_addr data : expected store in order
# C n : cycles from reset release to halted
P 000 01900093
P 004 FF900113
P 008 002081B3
P 00C 40208233
P 010 0020F2B3
P 014 0020E333
P 018 0020C3B3
P 01C 00112433
P 020 0F00C493
P 024 0FF17513
P 028 01E0A593
P 02C 7000E613
P 030 60302023
P 034 60402223
P 038 60502423
P 03C 60602623
P 040 60702823
P 044 60802A23
P 048 60902C23
P 04C 60A02E23
P 050 62B02023
P 054 62C02223
P 058 40002683
P 05C 40402703
P 060 62D02423
P 064 62E02623
P 068 00208463
P 06C 62302823
P 070 00209463
P 074 62402A23
P 078 00318463
P 07C 62502C23
P 080 00631463
P 084 62602E23
P 088 00C007EF
P 08C 64102023
P 090 64202223
P 094 64F02423
P 098 0A400813
P 09C 001808E7
P 0A0 64102623
P 0A4 65102823
P 0A8 00000073
P 400 CAFEF00D
P 404 12345678
S 600 00000012
S 604 00000020
S 608 00000019
S 60C FFFFFFF9
S 610 FFFFFFE0
S 614 00000001
S 618 000000E9
S 61C 000000F9
S 620 00000001
S 624 00000719
S 628 CAFEF00D
S 62C 12345678
S 630 00000012
S 63C FFFFFFF9
S 648 0000008C
S 650 000000A0
C 351

// ==== src.f ====
design/cpuPkg.sv
design/microController.sv
design/stateSequencer.sv
design/aluUnit.sv
design/regFile.sv
design/immGen.sv
design/multiCycleCpu.sv
sim/cpuBus_chk.sv
sim/cpuTb.sv
